// ==== verilog/sel_pkg.sv ====
`default_nettype none

package sel_pkg;

	// sample width on every data path
	localparam int data_w = 18;
	// cycles per time-multiplexed frame
	localparam int frame_len = 8;
	// magnitude setpoint to X-domain scale, product taken >> 17
	localparam int cordic_comp = 96667;
	// one radian as a 17-bit fraction of a revolution
	localparam int one_radian = 20861;
	// right shift after each gain product
	localparam int pi_shift = 17;

	typedef enum logic [3:0] {
		addr_set_m      = 4'd0,
		addr_set_p      = 4'd1,
		addr_ph_offset  = 4'd2,
		addr_sel_thresh = 4'd3,
		addr_kp_x       = 4'd4,
		addr_ki_x       = 4'd5,
		addr_kp_y       = 4'd6,
		addr_ki_y       = 4'd7,
		addr_lim_x_hi   = 4'd8,
		addr_lim_x_lo   = 4'd9,
		addr_lim_y_hi   = 4'd10,
		addr_lim_y_lo   = 4'd11,
		addr_ctrl       = 4'd12
	} reg_addr_e;

	typedef struct packed {
		logic [15:0] rsvd;
		logic set_slew;
		logic sel_en;
	} ctrl_flags_t;

	// one host word, a signed control value or the flag bits of addr_ctrl
	typedef union packed {
		logic signed [data_w-1:0] value;
		ctrl_flags_t flags;
	} host_data_u;

	typedef struct packed {
		logic stb;
		reg_addr_e addr;
		host_data_u data;
	} host_wr_t;

	typedef struct packed {
		logic signed [data_w-1:0] kp;
		logic signed [data_w-1:0] ki;
		logic signed [data_w-1:0] lim_hi;
		logic signed [data_w-1:0] lim_lo;
	} pi_gain_t;

	typedef struct packed {
		logic signed [data_w-1:0] set_m;
		logic signed [data_w-1:0] set_p;
		logic signed [data_w-1:0] ph_offset;
		logic signed [data_w-1:0] sel_thresh;
		pi_gain_t gain_x;
		pi_gain_t gain_y;
		logic sel_en;
		logic set_slew;
	} loop_cfg_t;

	typedef struct packed {
		logic [3:0] mag_over;
		logic [3:0] ph_over;
		logic x_hi;
		logic y_hi;
		logic x_lo;
		logic y_lo;
	} cmp_event_t;

	// chan 0 is X, 1 is Y; hold clears the integrator
	typedef struct packed {
		logic stb;
		logic chan;
		logic signed [data_w-1:0] err;
		logic hold;
	} pi_err_t;

endpackage

`default_nettype wire

// ==== verilog/sel_ctrl_regs.sv ====
`default_nettype none

module sel_ctrl_regs (
	input logic clk,
	input logic rst_n,
	input logic sync,
	input sel_pkg::host_wr_t host_wr,
	output sel_pkg::loop_cfg_t cfg
);

	// staged copy, written by the host at any cycle
	sel_pkg::loop_cfg_t shadow;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			shadow <= '0;
			cfg <= '0;
		end else begin
			if (host_wr.stb) begin
				case (host_wr.addr)
					sel_pkg::addr_set_m: shadow.set_m <= host_wr.data.value;
					sel_pkg::addr_set_p: shadow.set_p <= host_wr.data.value;
					sel_pkg::addr_ph_offset: shadow.ph_offset <= host_wr.data.value;
					sel_pkg::addr_sel_thresh: shadow.sel_thresh <= host_wr.data.value;
					sel_pkg::addr_kp_x: shadow.gain_x.kp <= host_wr.data.value;
					sel_pkg::addr_ki_x: shadow.gain_x.ki <= host_wr.data.value;
					sel_pkg::addr_kp_y: shadow.gain_y.kp <= host_wr.data.value;
					sel_pkg::addr_ki_y: shadow.gain_y.ki <= host_wr.data.value;
					sel_pkg::addr_lim_x_hi: shadow.gain_x.lim_hi <= host_wr.data.value;
					sel_pkg::addr_lim_x_lo: shadow.gain_x.lim_lo <= host_wr.data.value;
					sel_pkg::addr_lim_y_hi: shadow.gain_y.lim_hi <= host_wr.data.value;
					sel_pkg::addr_lim_y_lo: shadow.gain_y.lim_lo <= host_wr.data.value;
					sel_pkg::addr_ctrl: begin
						// flag view of the same word
						shadow.sel_en <= host_wr.data.flags.sel_en;
						shadow.set_slew <= host_wr.data.flags.set_slew;
					end
					default: begin
					end
				endcase
			end
			// whole set moves at the frame boundary
			// a write in the sync cycle itself waits one more frame
			if (sync) begin
				cfg <= shadow;
			end
		end
	end

	// host must only use defined register addresses
	a_host_addr: assert property (@(posedge clk) disable iff (!rst_n)
		host_wr.stb |-> (host_wr.addr <= sel_pkg::addr_ctrl));

endmodule

`default_nettype wire

// ==== verilog/setpoint_slew.sv ====
`default_nettype none

module setpoint_slew #(
	parameter int slew_shift = 8
) (
	input logic clk,
	input logic rst_n,
	input logic step,
	input logic enable,
	input logic signed [17:0] target,
	output logic signed [17:0] active
);

	// largest move per step
	localparam logic signed [18:0] max_step = 19'sd1 <<< slew_shift;

	logic signed [18:0] diff;
	logic near;

	// one extra bit so the difference cannot wrap
	assign diff = {target[17], target} - {active[17], active};
	// within one step of target, land on it exactly
	assign near = (diff <= max_step) && (diff >= -max_step);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= '0;
		end else if (step) begin
			if (!enable || near) begin
				active <= target;
			end else if (diff > 0) begin
				active <= active + max_step[17:0];
			end else begin
				active <= active - max_step[17:0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/xy_pi_clip.sv ====
`default_nettype none

module xy_pi_clip (
	input logic clk,
	input logic rst_n,
	input sel_pkg::pi_err_t err_in,
	input sel_pkg::pi_gain_t gain_x,
	input sel_pkg::pi_gain_t gain_y,
	output logic signed [17:0] drive_x,
	output logic signed [17:0] drive_y,
	output logic [1:0] clip_hi,
	output logic [1:0] clip_lo
);

	localparam int dw = sel_pkg::data_w;
	localparam int pw = 2 * dw;
	// gain term width after the shift
	localparam int tw = pw - sel_pkg::pi_shift;
	localparam int sw = tw + 1;

	// s1 is one cycle after the strobe, s2 two cycles after
	sel_pkg::pi_err_t s1, s2;
	sel_pkg::pi_gain_t g_mul, g1, g2;
	logic signed [dw-1:0] integ_x, integ_y, integ_s1, integ_s2;
	logic signed [dw-1:0] mul_k, mul_e, int_clip, out_clip;
	logic signed [pw-1:0] prod, prod_q;
	logic signed [tw-1:0] ki_term, kp_term;
	logic signed [sw-1:0] int_sum, out_sum;
	logic out_hi, out_lo;

	// hi wins at or above lim_hi, lo below lim_lo
	function automatic logic signed [dw-1:0] clip(input logic signed [sw-1:0] v,
			input logic signed [dw-1:0] hi, input logic signed [dw-1:0] lo);
		if (v >= hi) begin
			return hi;
		end else if (v < lo) begin
			return lo;
		end
		return v[dw-1:0];
	endfunction

	assign g1 = s1.chan ? gain_y : gain_x;
	assign g2 = s2.chan ? gain_y : gain_x;

	// single multiplier
	// ki on the strobe cycle straight from the input, kp two cycles later
	assign g_mul = err_in.stb ? (err_in.chan ? gain_y : gain_x) : g2;
	assign mul_k = err_in.stb ? g_mul.ki : g_mul.kp;
	assign mul_e = err_in.stb ? err_in.err : s2.err;
	assign prod = mul_k * mul_e;

	assign ki_term = tw'(prod_q >>> sel_pkg::pi_shift);
	assign kp_term = tw'(prod >>> sel_pkg::pi_shift);

	// integrator step uses the registered ki product
	assign integ_s1 = s1.chan ? integ_y : integ_x;
	assign int_sum = sw'(integ_s1) + sw'(ki_term);
	assign int_clip = clip(int_sum, g1.lim_hi, g1.lim_lo);

	// output sum sees the integrator already updated at s1
	assign integ_s2 = s2.chan ? integ_y : integ_x;
	assign out_sum = sw'(integ_s2) + sw'(kp_term);
	assign out_clip = clip(out_sum, g2.lim_hi, g2.lim_lo);
	assign out_hi = out_sum >= g2.lim_hi;
	assign out_lo = !out_hi && (out_sum < g2.lim_lo);

	always_ff @(posedge clk) begin
		prod_q <= prod;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1 <= '0;
			s2 <= '0;
			integ_x <= '0;
			integ_y <= '0;
			drive_x <= '0;
			drive_y <= '0;
			clip_hi <= '0;
			clip_lo <= '0;
		end else begin
			s1 <= err_in;
			s2 <= s1;
			// hold empties the integrator, output is then kp alone
			if (s1.stb && s1.chan) begin
				integ_y <= s1.hold ? '0 : int_clip;
			end
			if (s1.stb && !s1.chan) begin
				integ_x <= s1.hold ? '0 : int_clip;
			end
			if (s2.stb && s2.chan) begin
				drive_y <= out_clip;
				clip_hi[1] <= out_hi;
				clip_lo[1] <= out_lo;
			end
			if (s2.stb && !s2.chan) begin
				drive_x <= out_clip;
				clip_hi[0] <= out_hi;
				clip_lo[0] <= out_lo;
			end
		end
	end

	// a new strobe may not land on a pending kp cycle
	a_mul_free: assert property (@(posedge clk) disable iff (!rst_n)
		!(err_in.stb && s2.stb));

	// integrator settles inside the limits in force when it was updated
	a_integ_x: assert property (@(posedge clk) disable iff (!rst_n)
		(s1.stb && !s1.chan && !s1.hold) |=>
		(integ_x <= $past(gain_x.lim_hi)) && (integ_x >= $past(gain_x.lim_lo)));
	a_integ_y: assert property (@(posedge clk) disable iff (!rst_n)
		(s1.stb && s1.chan && !s1.hold) |=>
		(integ_y <= $past(gain_y.lim_hi)) && (integ_y >= $past(gain_y.lim_lo)));

endmodule

`default_nettype wire

// ==== verilog/lock_detect.sv ====
`default_nettype none

module lock_detect #(
	parameter int thresh_shift = 9
) (
	input logic clk,
	input logic rst_n,
	input logic mag_stb,
	input logic ph_stb,
	input logic [16:0] abs_err,
	input logic signed [17:0] set_m,
	output logic [7:0] over
);

	logic [1:0] load;
	logic [16:0] base [2];

	assign load = {ph_stb, mag_stb};
	// coarsest threshold of each channel, finer ones by halving
	assign base[0] = 17'(set_m >>> thresh_shift);
	assign base[1] = 17'(sel_pkg::one_radian >> thresh_shift);

	for (genvar c = 0; c < 2; c++) begin : g_chan
		logic [16:0] err_q, thr_q, cmp_a, cmp_b;
		logic [1:0] idx;
		logic busy;
		logic [3:0] flags;

		// first compare straight from the input, then recirculate
		assign cmp_a = load[c] ? abs_err : err_q;
		assign cmp_b = load[c] ? base[c] : thr_q;

		always_ff @(posedge clk) begin
			err_q <= cmp_a;
			thr_q <= cmp_b >> 1;
		end

		always_ff @(posedge clk) begin
			if (!rst_n) begin
				idx <= '0;
				busy <= 1'b0;
				flags <= '0;
			end else if (load[c] || busy) begin
				// strictly above the threshold
				flags[load[c] ? 2'd0 : idx] <= cmp_a > cmp_b;
				idx <= load[c] ? 2'd1 : idx + 2'd1;
				busy <= load[c] || (idx != 2'd3);
			end
		end

		// magnitude in the low nibble, phase in the high one
		assign over[4*c +: 4] = flags;
	end

endmodule

`default_nettype wire

// ==== verilog/mp_proc.sv ====
`default_nettype none

module mp_proc #(
	parameter int thresh_shift = 9,
	parameter int slew_shift = 8
) (
	input logic clk,
	input logic rst_n,
	input logic sync,
	input logic signed [17:0] in_mp,
	input sel_pkg::loop_cfg_t cfg,
	output logic out_sync,
	output logic signed [17:0] out_xy,
	output logic signed [18:0] out_ph,
	output sel_pkg::cmp_event_t cmp_event
);

	localparam int cw = $clog2(sel_pkg::frame_len);
	localparam logic signed [17:0] comp = 18'(sel_pkg::cordic_comp);

	logic [cw-1:0] slot_q, slot;
	logic running, amp_ok;
	logic step_stb, mag_stb, ph_stb, cap_stb;
	logic signed [17:0] cav_m, cav_p, set_m_act, mag_err, ph_err, drive_p;
	logic signed [17:0] drive_x, drive_y;
	logic signed [18:0] mag_diff;
	logic signed [35:0] set_prod;
	logic [16:0] err_abs;
	logic [1:0] clip_hi, clip_lo;
	logic [7:0] over;
	sel_pkg::pi_err_t pi_err;
	// frame k results, shown during frame k+1
	logic signed [17:0] q_x, q_y, q_set_x, q_drive_p, q_set_p;

	// slot 0 is the sync cycle itself
	assign slot = sync ? '0 : slot_q;

	// nothing runs before the first sync
	assign step_stb = running && (slot == cw'(1));
	assign mag_stb = running && (slot == cw'(2));
	assign ph_stb = running && (slot == cw'(3));
	assign cap_stb = running && (slot == cw'(sel_pkg::frame_len - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_q <= '0;
			running <= 1'b0;
			amp_ok <= 1'b0;
		end else begin
			slot_q <= slot + cw'(1);
			running <= running || sync;
			// hysteresis, on above sel_thresh, off below half of it
			if (step_stb && (cav_m > cfg.sel_thresh)) begin
				amp_ok <= 1'b1;
			end else if (step_stb && (cav_m < (cfg.sel_thresh >>> 1))) begin
				amp_ok <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (slot == cw'(0)) begin
			cav_m <= in_mp;
		end
		if (slot == cw'(1)) begin
			cav_p <= in_mp;
		end
		// X setpoint, scaled for the CORDIC gain
		set_prod <= set_m_act * comp;
	end

	// steps once per frame, after cfg has moved to this frame
	setpoint_slew #(.slew_shift(slew_shift)) u_slew (
		.clk(clk), .rst_n(rst_n), .step(step_stb), .enable(cfg.set_slew),
		.target(cfg.set_m), .active(set_m_act)
	);

	// magnitude error saturates, phase error wraps
	assign mag_diff = {cav_m[17], cav_m} - {set_m_act[17], set_m_act};
	assign mag_err = (mag_diff[18] == mag_diff[17]) ? mag_diff[17:0] :
		{mag_diff[18], {17{~mag_diff[18]}}};
	assign ph_err = cav_p - cfg.set_p;

	// X in slot 2, Y in slot 3
	assign pi_err.stb = mag_stb || ph_stb;
	assign pi_err.chan = ph_stb;
	assign pi_err.err = ph_stb ? ph_err : mag_err;
	assign pi_err.hold = !amp_ok;

	xy_pi_clip u_pi (
		.clk(clk), .rst_n(rst_n), .err_in(pi_err), .gain_x(cfg.gain_x), .gain_y(cfg.gain_y),
		.drive_x(drive_x), .drive_y(drive_y), .clip_hi(clip_hi), .clip_lo(clip_lo)
	);

	// ones-complement magnitude, -1 reads as 0
	assign err_abs = pi_err.err[17] ? ~pi_err.err[16:0] : pi_err.err[16:0];

	// magnitude thresholds scale with the active setpoint
	lock_detect #(.thresh_shift(thresh_shift)) u_lock (
		.clk(clk), .rst_n(rst_n), .mag_stb(mag_stb), .ph_stb(ph_stb),
		.abs_err(err_abs), .set_m(set_m_act), .over(over)
	);

	// phase is passed on only while SEL tracking is allowed
	assign drive_p = (cfg.sel_en && amp_ok) ? cav_p + cfg.ph_offset : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q_x <= '0;
			q_y <= '0;
			q_set_x <= '0;
			q_drive_p <= '0;
			q_set_p <= '0;
			cmp_event <= '0;
		end else if (cap_stb) begin
			q_x <= drive_x;
			q_y <= drive_y;
			q_set_x <= set_prod[34:17];
			q_drive_p <= drive_p;
			q_set_p <= cfg.set_p;
			cmp_event <= '{mag_over: over[3:0], ph_over: over[7:4], x_hi: clip_hi[0],
				y_hi: clip_hi[1], x_lo: clip_lo[0], y_lo: clip_lo[1]};
		end
	end

	assign out_sync = sync;

	// output slot multiplexer, phases widened by a zero LSB
	always_comb begin
		out_xy = '0;
		out_ph = '0;
		case (slot)
			cw'(0): out_xy = q_x;
			cw'(1): begin
				out_xy = q_y;
				out_ph = {q_drive_p, 1'b0};
			end
			cw'(2): out_xy = q_set_x;
			cw'(3): out_ph = {q_set_p, 1'b0};
			default: begin
			end
		endcase
	end

	// once started, sync comes back every frame_len cycles
	a_sync_period: assert property (@(posedge clk) disable iff (!rst_n)
		sync |=> !sync [*(sel_pkg::frame_len - 1)] ##1 sync);

endmodule

`default_nettype wire

// ==== verilog/sel_loop_top.sv ====
`default_nettype none

module sel_loop_top #(
	parameter int thresh_shift = 9,
	parameter int slew_shift = 8
) (
	input logic clk,
	input logic rst_n,
	input logic sync,
	input logic signed [17:0] in_mp,
	input sel_pkg::host_wr_t host_wr,
	output logic out_sync,
	output logic signed [17:0] out_xy,
	output logic signed [18:0] out_ph,
	output sel_pkg::cmp_event_t cmp_event
);

	// applied controls, steady for a whole frame
	sel_pkg::loop_cfg_t cfg;

	sel_ctrl_regs u_regs (
		.clk(clk), .rst_n(rst_n), .sync(sync), .host_wr(host_wr), .cfg(cfg)
	);

	mp_proc #(.thresh_shift(thresh_shift), .slew_shift(slew_shift)) u_proc (
		.clk(clk), .rst_n(rst_n), .sync(sync), .in_mp(in_mp), .cfg(cfg),
		.out_sync(out_sync), .out_xy(out_xy), .out_ph(out_ph), .cmp_event(cmp_event)
	);

endmodule

`default_nettype wire

// ==== test/sel_loop_tb.sv ====
`default_nettype none

module sel_loop_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int thresh_shift = 9;
	localparam int slew_shift = 4;
	localparam longint slew_step = 1 << slew_shift;
	localparam int sync_timeout = 16;

	logic clk;
	logic rst_n;
	logic sync;
	logic signed [17:0] in_mp;
	sel_pkg::host_wr_t host_wr;
	logic out_sync;
	logic signed [17:0] out_xy;
	logic signed [18:0] out_ph;
	sel_pkg::cmp_event_t cmp_event;

	// host writes waiting for a free slot
	sel_pkg::host_wr_t wr_q[$];

	// reference model state
	sel_pkg::loop_cfg_t shadow_m;
	logic amp_ok_m;
	longint act_m;
	longint ix_m;
	longint iy_m;

	// expected output frame, presented during the frame being driven
	logic signed [17:0] exp_xy [8];
	logic signed [18:0] exp_ph [8];
	sel_pkg::cmp_event_t exp_ev;

	logic [31:0] lfsr;
	int xy_errs;
	int ph_errs;
	int ev_errs;
	int sync_errs;

	sel_loop_top #(.thresh_shift(thresh_shift), .slew_shift(slew_shift)) DUT (
		.clk(clk), .rst_n(rst_n), .sync(sync), .in_mp(in_mp), .host_wr(host_wr),
		.out_sync(out_sync), .out_xy(out_xy), .out_ph(out_ph), .cmp_event(cmp_event)
	);

	always #4 clk = ~clk;

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	task automatic check_xy(input string what, input logic signed [17:0] got,
			input logic signed [17:0] want);
		if (got !== want) begin
			xy_errs++;
			$display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic check_ph(input string what, input logic signed [18:0] got,
			input logic signed [18:0] want);
		if (got !== want) begin
			ph_errs++;
			$display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic check_event(input string what, input sel_pkg::cmp_event_t got,
			input sel_pkg::cmp_event_t want);
		if (got !== want) begin
			ev_errs++;
			$display("ERROR %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_sync(input string what, input logic got, input logic want);
		if (got !== want) begin
			sync_errs++;
			$display("ERROR %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic queue_write(input sel_pkg::reg_addr_e addr, input int value);
		sel_pkg::host_wr_t w;
		w.stb = 1'b1;
		w.addr = addr;
		w.data.value = 18'(value);
		wr_q.push_back(w);
	endtask

	task automatic queue_ctrl(input logic sel_en, input logic set_slew);
		sel_pkg::host_wr_t w;
		w = '0;
		w.stb = 1'b1;
		w.addr = sel_pkg::addr_ctrl;
		w.data.flags.sel_en = sel_en;
		w.data.flags.set_slew = set_slew;
		wr_q.push_back(w);
	endtask

	// register map as seen by the host
	function automatic sel_pkg::loop_cfg_t apply_write(input sel_pkg::loop_cfg_t c,
			input sel_pkg::host_wr_t w);
		case (w.addr)
			sel_pkg::addr_set_m: c.set_m = w.data.value;
			sel_pkg::addr_set_p: c.set_p = w.data.value;
			sel_pkg::addr_ph_offset: c.ph_offset = w.data.value;
			sel_pkg::addr_sel_thresh: c.sel_thresh = w.data.value;
			sel_pkg::addr_kp_x: c.gain_x.kp = w.data.value;
			sel_pkg::addr_ki_x: c.gain_x.ki = w.data.value;
			sel_pkg::addr_kp_y: c.gain_y.kp = w.data.value;
			sel_pkg::addr_ki_y: c.gain_y.ki = w.data.value;
			sel_pkg::addr_lim_x_hi: c.gain_x.lim_hi = w.data.value;
			sel_pkg::addr_lim_x_lo: c.gain_x.lim_lo = w.data.value;
			sel_pkg::addr_lim_y_hi: c.gain_y.lim_hi = w.data.value;
			sel_pkg::addr_lim_y_lo: c.gain_y.lim_lo = w.data.value;
			sel_pkg::addr_ctrl: begin
				c.sel_en = w.data.flags.sel_en;
				c.set_slew = w.data.flags.set_slew;
			end
			default: begin
			end
		endcase
		return c;
	endfunction

	function automatic longint clip_lim(input longint v, input sel_pkg::pi_gain_t g);
		if (v >= g.lim_hi) begin
			return g.lim_hi;
		end else if (v < g.lim_lo) begin
			return g.lim_lo;
		end
		return v;
	endfunction

	// -1 counts as 0
	function automatic longint ones_abs(input longint e);
		return (e < 0) ? -e - 1 : e;
	endfunction

	// one channel: integrator first, then output from the new integrator
	task automatic pi_model(input longint err, input sel_pkg::pi_gain_t g, input logic hold,
			inout longint integ, output logic signed [17:0] drive, output logic hi,
			output logic lo);
		longint sum;
		if (hold) begin
			integ = 0;
		end else begin
			integ = clip_lim(integ + ((longint'(g.ki) * err) >>> sel_pkg::pi_shift), g);
		end
		sum = integ + ((longint'(g.kp) * err) >>> sel_pkg::pi_shift);
		drive = 18'(clip_lim(sum, g));
		hi = sum >= g.lim_hi;
		lo = !hi && (sum < g.lim_lo);
	endtask

	// results of one frame, shown during the next one
	task automatic model_frame(input longint cm, input logic signed [17:0] cp,
			input sel_pkg::loop_cfg_t c);
		longint diff;
		longint me;
		logic signed [17:0] pe;
		logic signed [17:0] dx;
		logic signed [17:0] dy;
		logic signed [17:0] dp;
		logic xh, xl, yh, yl;
		// amplitude hysteresis
		if (cm > c.sel_thresh) begin
			amp_ok_m = 1'b1;
		end else if (cm < (c.sel_thresh >>> 1)) begin
			amp_ok_m = 1'b0;
		end
		diff = c.set_m - act_m;
		if (!c.set_slew || (diff <= slew_step && diff >= -slew_step)) begin
			act_m = c.set_m;
		end else if (diff > 0) begin
			act_m = act_m + slew_step;
		end else begin
			act_m = act_m - slew_step;
		end
		// saturated magnitude error, wrapped phase error
		me = cm - act_m;
		if (me > 131071) begin
			me = 131071;
		end else if (me < -131072) begin
			me = -131072;
		end
		pe = cp - c.set_p;
		pi_model(me, c.gain_x, !amp_ok_m, ix_m, dx, xh, xl);
		pi_model(pe, c.gain_y, !amp_ok_m, iy_m, dy, yh, yl);
		dp = (c.sel_en && amp_ok_m) ? cp + c.ph_offset : '0;
		for (int s = 0; s < 8; s++) begin
			exp_xy[s] = '0;
			exp_ph[s] = '0;
		end
		exp_xy[0] = dx;
		exp_xy[1] = dy;
		exp_xy[2] = 18'((act_m * sel_pkg::cordic_comp) >>> 17);
		exp_ph[1] = {dp, 1'b0};
		exp_ph[3] = {c.set_p, 1'b0};
		for (int i = 0; i < 4; i++) begin
			exp_ev.mag_over[i] = ones_abs(me) > (act_m >>> (thresh_shift + i));
			exp_ev.ph_over[i] = ones_abs(pe) > (sel_pkg::one_radian >> (thresh_shift + i));
		end
		exp_ev.x_hi = xh;
		exp_ev.x_lo = xl;
		exp_ev.y_hi = yh;
		exp_ev.y_lo = yl;
	endtask

	task automatic wait_out_sync();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!out_sync && n < sync_timeout);
		if (!out_sync) begin
			$display("timed out after %0d cycles waiting for out_sync", n);
			$display("Checks failed");
			$finish;
		end
	endtask

	// one 8-slot frame, outputs of the previous frame checked at each negedge
	task automatic run_frame(input logic signed [17:0] cm, input logic signed [17:0] cp);
		sel_pkg::loop_cfg_t c;
		// staged controls become the applied set at this sync
		c = shadow_m;
		for (int s = 0; s < 8; s++) begin
			sync = (s == 0);
			in_mp = (s == 0) ? cm : ((s == 1) ? cp : '0);
			host_wr = '0;
			// writes land mid-frame only
			if (s >= 2 && wr_q.size() > 0) begin
				host_wr = wr_q.pop_front();
				shadow_m = apply_write(shadow_m, host_wr);
			end
			if (s == 0) begin
				wait_out_sync();
			end else begin
				@(negedge clk);
			end
			check_sync($sformatf("out_sync slot %0d", s), out_sync, s == 0);
			check_xy($sformatf("out_xy slot %0d", s), out_xy, exp_xy[s]);
			check_ph($sformatf("out_ph slot %0d", s), out_ph, exp_ph[s]);
			check_event($sformatf("cmp_event slot %0d", s), cmp_event, exp_ev);
			@(posedge clk);
			#1;
		end
		model_frame(cm, cp, c);
	endtask

	// zero frame first, then controls written mid-frame
	task automatic test_reset_write();
		queue_write(sel_pkg::addr_set_m, 40960);
		queue_write(sel_pkg::addr_set_p, 1234);
		queue_write(sel_pkg::addr_sel_thresh, 20000);
		queue_write(sel_pkg::addr_lim_x_hi, 60000);
		queue_write(sel_pkg::addr_lim_x_lo, -60000);
		queue_write(sel_pkg::addr_lim_y_hi, 60000);
		queue_write(sel_pkg::addr_lim_y_lo, -60000);
		for (int f = 0; f < 4; f++) begin
			run_frame(40000, 500);
		end
	endtask

	task automatic test_hysteresis();
		int ramp [10];
		// on above 20000, off below 10000
		ramp = '{25000, 15000, 9000, 15000, 20000, 20001, 12000, 25000, 25000, 25000};
		queue_write(sel_pkg::addr_ph_offset, 5000);
		queue_ctrl(1'b1, 1'b0);
		run_frame(25000, 129000);
		for (int f = 0; f < 10; f++) begin
			// tracking switched off for the last frames
			if (f == 7) begin
				queue_ctrl(1'b0, 1'b0);
			end
			run_frame(18'(ramp[f]), 129000);
		end
		queue_ctrl(1'b1, 1'b0);
	endtask

	task automatic test_pi();
		logic signed [17:0] cm;
		logic signed [17:0] cp;
		queue_write(sel_pkg::addr_kp_x, 30000);
		queue_write(sel_pkg::addr_ki_x, 8000);
		queue_write(sel_pkg::addr_kp_y, -20000);
		queue_write(sel_pkg::addr_ki_y, 5000);
		for (int f = 0; f < 14; f++) begin
			// two low frames drop amp_ok and hold the integrators
			if (f == 6 || f == 7) begin
				cm = 5000;
			end else begin
				cm = 18'(40960 + rand_bits(12) - 2048);
			end
			cp = 18'(rand_bits(18));
			run_frame(cm, cp);
		end
	endtask

	task automatic test_clip();
		queue_write(sel_pkg::addr_lim_x_hi, 3000);
		queue_write(sel_pkg::addr_lim_x_lo, -2500);
		queue_write(sel_pkg::addr_lim_y_hi, 4000);
		queue_write(sel_pkg::addr_lim_y_lo, -3500);
		run_frame(40960, 1234);
		for (int f = 0; f < 4; f++) begin
			run_frame(120000, 61234);
			run_frame(15000, -58766);
		end
	endtask

	task automatic test_slew();
		queue_ctrl(1'b1, 1'b1);
		queue_write(sel_pkg::addr_set_m, 41060);
		for (int f = 0; f < 9; f++) begin
			run_frame(41000, 1234);
		end
		// without slew the setpoint jumps
		queue_ctrl(1'b1, 1'b0);
		queue_write(sel_pkg::addr_set_m, 40460);
		for (int f = 0; f < 3; f++) begin
			run_frame(41000, 1234);
		end
	endtask

	task automatic test_lock();
		int mt;
		int pt;
		queue_write(sel_pkg::addr_set_m, 40960);
		run_frame(40960, 1234);
		run_frame(40960, 1234);
		for (int i = 0; i < 4; i++) begin
			mt = 40960 >>> (thresh_shift + i);
			pt = sel_pkg::one_radian >> (thresh_shift + i);
			// just over, then exactly at the threshold, both signs
			run_frame(18'(40960 + mt + 1), 18'(1234 + pt + 1));
			run_frame(18'(40960 + mt), 18'(1234 + pt));
			run_frame(18'(40960 - mt - 2), 18'(1234 - pt - 2));
			run_frame(18'(40960 - mt - 1), 18'(1234 - pt - 1));
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		sync = 1'b0;
		in_mp = '0;
		host_wr = '0;
		lfsr = 32'he5f20e2d;
		xy_errs = 0;
		ph_errs = 0;
		ev_errs = 0;
		sync_errs = 0;
		shadow_m = '0;
		amp_ok_m = 1'b0;
		act_m = 0;
		ix_m = 0;
		iy_m = 0;
		// reset leaves an all-zero output frame
		for (int s = 0; s < 8; s++) begin
			exp_xy[s] = '0;
			exp_ph[s] = '0;
		end
		exp_ev = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset_write();
		test_hysteresis();
		test_pi();
		test_clip();
		test_slew();
		test_lock();
		// results of the last frame
		run_frame(0, 0);
		$display("errors: out_sync %0d, out_xy %0d, out_ph %0d, cmp_event %0d",
			sync_errs, xy_errs, ph_errs, ev_errs);
		if (sync_errs + xy_errs + ph_errs + ev_errs == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/sel_pkg.sv
verilog/sel_ctrl_regs.sv
verilog/setpoint_slew.sv
verilog/xy_pi_clip.sv
verilog/lock_detect.sv
verilog/mp_proc.sv
verilog/sel_loop_top.sv
test/sel_loop_tb.sv

// ==== Bender.yml ====
package:
  name: sel_loop

sources:
  - verilog/sel_pkg.sv
  - verilog/sel_ctrl_regs.sv
  - verilog/setpoint_slew.sv
  - verilog/xy_pi_clip.sv
  - verilog/lock_detect.sv
  - verilog/mp_proc.sv
  - verilog/sel_loop_top.sv
  - target: test
    files:
      - test/sel_loop_tb.sv
